// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    // Data and address width, fixed by RV32I
    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // OP_NOP must stay at zero so an all-zero decode entry is a bubble
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLT  = 4'd6,
        OP_ADDI = 4'd7,
        OP_BEQ  = 4'd8,
        OP_BNE  = 4'd9,
        OP_JAL  = 4'd10
    } op_e;

    // Fetch/decode register entry
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_t;

    // Decode/execute register entry
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        logic      rd_valid;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     imm;
        word_t     pc;
    } decode_t;

    // One register write leaving the pipeline
    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
    } retire_t;

    // Branch outcome from execute
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`default_nettype none

module fetch_unit import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic      clk,
    input  logic      rst,
    input  word_t     instr_in,
    input  logic      fetch_stall,
    input  redirect_t redirect,
    output word_t     pc_out,
    output fetch_t    fetch
);

    // Address of the word arriving on instr_in this cycle
    word_t resp_pc;
    // Low when that word belongs to an abandoned request
    logic  resp_valid;
    logic  lost;
    logic  accept;

    // A stalled word only needs a refetch if it was wanted
    assign lost   = fetch_stall && resp_valid;
    assign accept = resp_valid && !fetch_stall && !redirect.taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_out     <= reset_pc;
            resp_pc    <= reset_pc;
            resp_valid <= 1'b0;
        end else begin
            resp_pc    <= pc_out;
            // Word of the current request comes back out of order after a refetch
            resp_valid <= !redirect.taken && !lost;
            if (redirect.taken) begin
                pc_out <= redirect.target;
            end else if (lost) begin
                pc_out <= resp_pc;
            end else begin
                pc_out <= pc_out + 32'd4;
            end
        end
    end

    // Fetch/decode register, bubbles for dropped words
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch <= '{pc: reset_pc, instr: nop_instr};
        end else begin
            fetch.pc    <= resp_pc;
            fetch.instr <= accept ? instr_in : nop_instr;
        end
    end

    // Execute targets and refetches both keep the stream word aligned
    assert property (@(posedge clk) disable iff (rst) pc_out[1:0] == 2'b00)
        else $error("fetch_unit: pc_out %h not word aligned", pc_out);

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      wr_en,
    input  retire_t   wr,
    output word_t     rs1_value,
    output word_t     rs2_value
);

    // x0 is not stored
    word_t regs [1:31];

    // Same-cycle write shows through to the reader
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && wr.rd == addr) begin
            value = wr.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_value = read_port(rs1);
        rs2_value = read_port(rs2);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.rd != '0) begin
            regs[wr.rd] <= wr.value;
        end
    end

    // Decode never marks x0 as a destination, so execute never retires it
    assert property (@(posedge clk) disable iff (rst) wr_en |-> wr.rd != '0)
        else $error("register_file: write to x0");

endmodule

`default_nettype wire

// File: rtl/decode_unit.sv
`default_nettype none

module decode_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  fetch_t    fetch,
    input  redirect_t redirect,
    input  word_t     rs1_value,
    input  word_t     rs2_value,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output decode_t   decoded
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // All-zero entry is OP_NOP with no destination
    localparam decode_t nop_entry = '0;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    word_t      imm;
    decode_t    entry;

    assign instr  = fetch.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Anything outside the subset becomes a bubble
    always_comb begin
        op = OP_NOP;
        case (opcode)
            opc_op: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b010:  op = OP_SLT;
                        3'b100:  op = OP_XOR;
                        3'b110:  op = OP_OR;
                        3'b111:  op = OP_AND;
                        default: op = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = OP_SUB;
                end
            end
            opc_op_imm: begin
                if (funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            opc_branch: begin
                if (funct3 == 3'b000) begin
                    op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = OP_BNE;
                end
            end
            opc_jal: op = OP_JAL;
            default: op = OP_NOP;
        endcase
    end

    // I, B or J immediate
    always_comb begin
        case (opcode)
            opc_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            opc_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:    imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        entry           = nop_entry;
        entry.op        = op;
        entry.rd        = instr[11:7];
        entry.rd_valid  = (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                      OP_ADDI, OP_JAL}) && instr[11:7] != '0;
        entry.rs1       = rs1;
        entry.rs2       = rs2;
        entry.rs1_value = rs1_value;
        entry.rs2_value = rs2_value;
        entry.imm       = imm;
        entry.pc        = fetch.pc;
    end

    // Decode/execute register, squashed behind a taken branch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decoded <= nop_entry;
        end else if (redirect.taken) begin
            decoded <= nop_entry;
        end else begin
            decoded <= entry;
        end
    end

    // Forwarding and the retire rule rely on this
    assert property (@(posedge clk) disable iff (rst) decoded.rd_valid |-> decoded.rd != '0)
        else $error("decode_unit: rd_valid with rd x0");

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`default_nettype none

module execute_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  decode_t   decoded,
    output redirect_t redirect,
    output logic      retire_valid,
    output retire_t   retire
);

    word_t op_a;
    word_t op_b;
    word_t result;
    logic  less;
    logic  taken;

    // Bypass from the writeback register
    // One instruction further back is covered by register file write-through
    always_comb begin
        op_a = decoded.rs1_value;
        op_b = decoded.rs2_value;
        if (retire_valid && retire.rd == decoded.rs1) begin
            op_a = retire.value;
        end
        if (retire_valid && retire.rd == decoded.rs2) begin
            op_b = retire.value;
        end
    end

    assign less = $signed(op_a) < $signed(op_b);

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (decoded.op)
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            OP_AND:  result = op_a & op_b;
            OP_OR:   result = op_a | op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_SLT:  result = {{(xlen-1){1'b0}}, less};
            OP_ADDI: result = op_a + decoded.imm;
            OP_BEQ:  taken = op_a == op_b;
            OP_BNE:  taken = op_a != op_b;
            OP_JAL: begin
                // Link value
                result = decoded.pc + 32'd4;
                taken  = 1'b1;
            end
            default: result = '0;
        endcase
    end

    // Branch and jump targets share one adder
    assign redirect = '{taken: taken, target: decoded.pc + decoded.imm};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= decoded.rd_valid;
        end
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        retire.rd    <= decoded.rd;
        retire.value <= result;
    end

    assert property (@(posedge clk) disable iff (rst)
        redirect.taken |-> decoded.op inside {OP_BEQ, OP_BNE, OP_JAL})
        else $error("execute_unit: redirect taken for op %s", decoded.op.name());

endmodule

`default_nettype wire

// File: rtl/riscv_core.sv
`default_nettype none

module riscv_core import core_pkg::*; #(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    rst,
    input  word_t   instr_in,
    input  logic    fetch_stall,
    output word_t   pc_out,
    output logic    retire_valid,
    output retire_t retire
);

    fetch_t    fetch;
    decode_t   decoded;
    redirect_t redirect;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_value;
    word_t     rs2_value;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .instr_in(instr_in),
        .fetch_stall(fetch_stall),
        .redirect(redirect),
        .pc_out(pc_out),
        .fetch(fetch)
    );

    decode_unit u_decode (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .redirect(redirect),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .rs1(rs1),
        .rs2(rs2),
        .decoded(decoded)
    );

    // Read by decode, written from the writeback register
    register_file u_regs (
        .clk(clk),
        .rst(rst),
        .rs1(rs1),
        .rs2(rs2),
        .wr_en(retire_valid),
        .wr(retire),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    execute_unit u_execute (
        .clk(clk),
        .rst(rst),
        .decoded(decoded),
        .redirect(redirect),
        .retire_valid(retire_valid),
        .retire(retire)
    );

endmodule

`default_nettype wire

// File: tb/tb_riscv_core.sv
`default_nettype none

module tb_riscv_core import core_pkg::*; ();

    localparam word_t reset_pc = 32'h0000_0000;

    // One program word with its expected retire and control flow
    typedef struct packed {
        word_t   instr;
        logic    retires;
        retire_t result;
        logic    taken;
        word_t   target;
    } entry_t;

    logic    clk;
    logic    rst;
    word_t   instr_in;
    logic    fetch_stall;
    word_t   pc_out;
    logic    retire_valid;
    retire_t retire;

    entry_t  prog_table[$];
    word_t   rom[$];
    retire_t expected[$];

    logic [31:0] rnd_state;
    int          cycle_limit = 0;
    int          cycle_count;

    // Reference fetch model state
    word_t model_pc;
    word_t model_resp_pc;
    logic  model_resp_valid;
    logic  fd_valid;
    word_t fd_pc;
    logic  ex_valid;
    word_t ex_pc;

    riscv_core #(
        .reset_pc(reset_pc)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .instr_in(instr_in),
        .fetch_stall(fetch_stall),
        .pc_out(pc_out),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_retire(input string name, input retire_t got, input retire_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got rd %h value %h, expected rd %h value %h",
                               name, got.rd, got.value, exp.rd, exp.value));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32I encoders
    function automatic word_t enc_alu(input op_e op, input reg_addr_t rd,
                                      input reg_addr_t rs1, input reg_addr_t rs2);
        logic [6:0] funct7;
        logic [2:0] funct3;
        funct7 = (op == OP_SUB) ? 7'h20 : 7'h00;
        case (op)
            OP_AND:  funct3 = 3'b111;
            OP_OR:   funct3 = 3'b110;
            OP_XOR:  funct3 = 3'b100;
            OP_SLT:  funct3 = 3'b010;
            default: funct3 = 3'b000;
        endcase
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_addi(input reg_addr_t rd, input reg_addr_t rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_branch(input logic [2:0] funct3, input reg_addr_t rs1,
                                         input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_jal(input reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_entry(input word_t instr, input logic retires, input reg_addr_t rd,
                             input word_t value, input logic taken, input word_t target);
        entry_t e;
        e.instr        = instr;
        e.retires      = retires;
        e.result.rd    = rd;
        e.result.value = value;
        e.taken        = taken;
        e.target       = target;
        prog_table.push_back(e);
    endtask

    // Expected results worked out by hand from the ISA
    task automatic build_program();
        add_entry(enc_addi(5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'h5, 1'b0, 32'h0);
        add_entry(enc_addi(5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hffff_fffd, 1'b0, 32'h0);
        add_entry(enc_alu(OP_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h2, 1'b0, 32'h0);
        add_entry(enc_alu(OP_SUB, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'hffff_fffd, 1'b0, 32'h0);
        add_entry(enc_alu(OP_AND, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'h5, 1'b0, 32'h0);
        add_entry(enc_alu(OP_OR, 5'd6, 5'd5, 5'd2), 1'b1, 5'd6, 32'hffff_fffd, 1'b0, 32'h0);
        add_entry(enc_alu(OP_XOR, 5'd7, 5'd6, 5'd1), 1'b1, 5'd7, 32'hffff_fff8, 1'b0, 32'h0);
        add_entry(enc_alu(OP_SLT, 5'd8, 5'd2, 5'd1), 1'b1, 5'd8, 32'h1, 1'b0, 32'h0);
        add_entry(enc_alu(OP_SLT, 5'd9, 5'd1, 5'd2), 1'b1, 5'd9, 32'h0, 1'b0, 32'h0);
        add_entry(enc_addi(5'd0, 5'd1, 12'd7), 1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        add_entry(enc_alu(OP_ADD, 5'd10, 5'd8, 5'd0), 1'b1, 5'd10, 32'h1, 1'b0, 32'h0);
        // BNE at 0x2c falls through
        add_entry(enc_branch(3'b001, 5'd10, 5'd8, 13'd16), 1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        add_entry(enc_addi(5'd11, 5'd10, 12'd1), 1'b1, 5'd11, 32'h2, 1'b0, 32'h0);
        // BEQ at 0x34 jumps to 0x40
        add_entry(enc_branch(3'b000, 5'd11, 5'd3, 13'd12), 1'b0, 5'd0, 32'h0, 1'b1, 32'h40);
        add_entry(enc_addi(5'd12, 5'd0, 12'd99), 1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        add_entry(enc_addi(5'd13, 5'd0, 12'd98), 1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        // JAL at 0x40 links 0x44 and jumps to 0x4c
        add_entry(enc_jal(5'd14, 21'd12), 1'b1, 5'd14, 32'h44, 1'b1, 32'h4c);
        add_entry(enc_addi(5'd15, 5'd0, 12'd1), 1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        add_entry(enc_addi(5'd16, 5'd0, 12'd2), 1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        add_entry(enc_alu(OP_ADD, 5'd17, 5'd14, 5'd11), 1'b1, 5'd17, 32'h46, 1'b0, 32'h0);
        add_entry(enc_alu(OP_XOR, 5'd18, 5'd17, 5'd14), 1'b1, 5'd18, 32'h2, 1'b0, 32'h0);
        add_entry(enc_addi(5'd19, 5'd18, 12'hfff), 1'b1, 5'd19, 32'h1, 1'b0, 32'h0);
        add_entry(enc_alu(OP_SUB, 5'd20, 5'd19, 5'd17), 1'b1, 5'd20, 32'hffff_ffbb, 1'b0, 32'h0);
        add_entry(enc_alu(OP_SLT, 5'd21, 5'd20, 5'd19), 1'b1, 5'd21, 32'h1, 1'b0, 32'h0);
    endtask

    // Past the end of the program the ROM reads as NOPs
    function automatic word_t rom_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] == 2'b00 && idx < rom.size()) begin
            return rom[idx];
        end
        return nop_instr;
    endfunction

    function automatic entry_t lookup_entry(input word_t addr);
        entry_t e;
        int     idx;
        e   = '0;
        idx = int'(addr >> 2);
        if (addr[1:0] == 2'b00 && idx < prog_table.size()) begin
            e = prog_table[idx];
        end
        return e;
    endfunction

    // Check the cycle that just ended, advance the model, drive the next cycle
    task automatic run_cycle();
        entry_t  ex_entry;
        retire_t exp_retire;
        logic    redirect_taken;
        logic    lost;
        logic    accept;
        word_t   next_pc;
        @(posedge clk);
        compare_word("pc_out", pc_out, model_pc);
        if (cycle_count == 0) begin
            compare_bit("retire_valid", retire_valid, 1'b0);
        end
        if (retire_valid) begin
            if (expected.size() == 0) begin
                fail_run("retire_valid pulsed with no instruction left to retire");
            end else begin
                exp_retire = expected.pop_front();
                compare_retire("retire", retire, exp_retire);
            end
        end
        ex_entry       = lookup_entry(ex_pc);
        redirect_taken = ex_valid && ex_entry.taken;
        // A stalled word is lost only if it was a wanted response
        lost           = fetch_stall && model_resp_valid;
        accept         = model_resp_valid && !fetch_stall && !redirect_taken;
        if (redirect_taken) begin
            next_pc = ex_entry.target;
        end else if (lost) begin
            next_pc = model_resp_pc;
        end else begin
            next_pc = model_pc + 32'd4;
        end
        ex_valid         = fd_valid && !redirect_taken;
        ex_pc            = fd_pc;
        fd_valid         = accept;
        fd_pc            = model_resp_pc;
        model_resp_valid = !redirect_taken && !lost;
        model_resp_pc    = model_pc;
        model_pc         = next_pc;
        cycle_count      = cycle_count + 1;
        rnd_state        = xorshift32(rnd_state);
        instr_in    <= rom_word(pc_out);
        fetch_stall <= (rnd_state[1:0] == 2'b00);
    endtask

    initial begin
        rst         = 1'b1;
        instr_in    = nop_instr;
        fetch_stall = 1'b0;
        rnd_state   = 32'ha10a_087f;
        cycle_count = 0;
        build_program();
        foreach (prog_table[i]) begin
            rom.push_back(prog_table[i].instr);
            if (prog_table[i].retires) begin
                expected.push_back(prog_table[i].result);
            end
        end
        cycle_limit = 20 * prog_table.size() + 100;
        // First reset edge loads the flops
        @(posedge clk);
        repeat (4) begin
            @(posedge clk);
            compare_word("pc_out", pc_out, reset_pc);
            compare_bit("retire_valid", retire_valid, 1'b0);
        end
        rst         <= 1'b0;
        instr_in    <= rom_word(pc_out);
        fetch_stall <= 1'b0;
        model_pc         = reset_pc;
        model_resp_pc    = reset_pc;
        model_resp_valid = 1'b0;
        fd_valid         = 1'b0;
        fd_pc            = reset_pc;
        ex_valid         = 1'b0;
        ex_pc            = reset_pc;
        while (expected.size() > 0) begin
            run_cycle();
        end
        // A few more cycles to catch stray retires
        repeat (8) begin
            run_cycle();
        end
        $display("test passed");
        $finish;
    end

    initial begin
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clk);
        fail_run("watchdog expired before every expected instruction retired");
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/riscv_core.sv
tb/tb_riscv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up
verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_riscv_core \
    && ./obj_dir/Vtb_riscv_core | tee /dev/stderr | grep -q '^test passed$' \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
